// File: src.f
source/sched_cfg_pkg.sv
source/sched_pkt_pkg.sv
source/issue_queue.sv
source/sched_regfile.sv
source/dispatch_arbiter.sv
source/stride_prefetcher.sv
source/be_scheduler.sv
verif/tb_be_scheduler.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f src.f --top-module tb_be_scheduler -o sim_be_scheduler

./obj_dir/sim_be_scheduler | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

// File: verif/tb_be_scheduler.sv
// testbench for the back-end scheduler: directed tests against a fetch credit model
`timescale 1ns/10ps

module tb_be_scheduler;

  import sched_cfg_pkg::*;
  import sched_pkt_pkg::*;

  localparam int queue_depth_lp = 4;
  // well above the two hundred or so cycles the tests take
  localparam int cycle_limit_lp = 2000;

  logic          clk;
  logic          rst_n;
  logic          fe_v;
  fetch_entry_s  fe_entry;
  logic          clear;
  logic          hazard;
  logic          resume;
  logic          irq_pending;
  wb_pkt_s       iwb;
  wb_pkt_s       fwb;
  logic          late_wb_v;
  logic          late_wb_force;
  late_wb_s      late_wb;
  commit_s       commit;
  logic          fe_credit;
  logic          late_wb_yumi;
  dispatch_pkt_s dispatch;

  dispatch_pkt_s disp_q [$];
  dpath_t        int_ref [num_regs];
  dpath_t        fp_ref [num_regs];
  logic [31:0]   rng_state = 32'h7e7e;
  int            errors = 0;
  int            monitor_errors = 0;
  int            cycles = 0;
  int            credit_pulses = 0;
  int            credits_used = 0;
  int            pulse_base = 0;

  be_scheduler #(.queue_depth_p(queue_depth_lp), .prefetch_depth_p(3)) i_dut
    (.clk_i(clk), .rst_n_i(rst_n), .fe_v_i(fe_v), .fe_entry_i(fe_entry)
     , .clear_i(clear), .hazard_i(hazard), .resume_i(resume), .irq_pending_i(irq_pending)
     , .iwb_i(iwb), .fwb_i(fwb), .late_wb_v_i(late_wb_v), .late_wb_force_i(late_wb_force)
     , .late_wb_i(late_wb), .commit_i(commit), .fe_credit_o(fe_credit)
     , .late_wb_yumi_o(late_wb_yumi), .dispatch_o(dispatch));

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit_lp)
    begin
      $display("timeout after %0d cycles, %0d errors so far", cycles, errors + monitor_errors);
      $display("Test failed");
      $finish;
    end
  end

  // record every dispatch and credit pulse in the middle of the cycle
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (dispatch.v)
        disp_q.push_back(dispatch);
      if (fe_credit)
        credit_pulses++;
      assert (late_wb_yumi == (dispatch.v && dispatch.kind == e_disp_late_wb))
        else
        begin
          monitor_errors++;
          $display("FAILED late_wb_yumi_o: got %h, dispatch kind %h", late_wb_yumi, dispatch.kind);
        end
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int credits_avail();
    return queue_depth_lp - credits_used + credit_pulses - pulse_base;
  endfunction

  // integer x0 always reads as zero
  function automatic dpath_t read_operand(input logic fp, input reg_addr_t addr);
    if (fp)
      return fp_ref[addr];
    return (addr == '0) ? '0 : int_ref[addr];
  endfunction

  function automatic fetch_entry_s make_entry(input vaddr_t pc, input reg_addr_t rs1,
                                              input reg_addr_t rs2, input reg_addr_t rs3,
                                              input logic [2:0] frs, input dpath_t imm);
    fetch_entry_s e;
    e        = '0;
    e.pc     = pc;
    e.instr  = {rs3, 2'b00, rs2, rs1, 3'b000, 5'd10, 7'b1000011};
    e.imm    = imm;
    e.frs1_v = frs[0];
    e.frs2_v = frs[1];
    e.frs3_v = frs[2];
    return e;
  endfunction

  function automatic dispatch_pkt_s instr_pkt(input fetch_entry_s e);
    dispatch_pkt_s p;
    p         = '0;
    p.v       = 1'b1;
    p.kind    = e_disp_instr;
    p.pc      = e.pc;
    p.instr   = e.instr;
    p.rd_addr = e.instr[11:7];
    p.rs1     = read_operand(e.frs1_v, e.instr[19:15]);
    p.rs2     = read_operand(e.frs2_v, e.instr[24:20]);
    p.imm     = e.frs3_v ? fp_ref[e.instr[31:27]] : e.imm;
    return p;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else
      begin
        errors++;
        $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
  endtask

  task automatic check_dispatch(input dispatch_pkt_s exp);
    dispatch_pkt_s got;
    int            waited;
    waited = 0;
    while (disp_q.size() == 0 && waited < 20)
    begin
      @(negedge clk);
      #1;
      waited++;
    end
    assert (disp_q.size() != 0)
      else
      begin
        errors++;
        $display("no dispatch arrived within 20 cycles, expected kind %0d", exp.kind);
      end
    if (disp_q.size() != 0)
    begin
      got = disp_q.pop_front();
      check_value("dispatch_o.kind", 64'(got.kind), 64'(exp.kind));
      check_value("dispatch_o.pc", 64'(got.pc), 64'(exp.pc));
      check_value("dispatch_o.instr", 64'(got.instr), 64'(exp.instr));
      check_value("dispatch_o.rd_addr", 64'(got.rd_addr), 64'(exp.rd_addr));
      check_value("dispatch_o.rs1", got.rs1, exp.rs1);
      check_value("dispatch_o.rs2", got.rs2, exp.rs2);
      check_value("dispatch_o.imm", got.imm, exp.imm);
      check_value("dispatch_o.exc", 64'(got.exc), 64'(exp.exc));
    end
  endtask

  task automatic expect_quiet(input int n);
    repeat (n)
    begin
      @(negedge clk);
      #1;
    end
    assert (disp_q.size() == 0)
      else
      begin
        errors++;
        $display("%0d unexpected dispatches, first of kind %0d", disp_q.size(), disp_q[0].kind);
        disp_q.delete();
      end
  endtask

  task automatic push_entry(input fetch_entry_s e);
    while (credits_avail() == 0)
      @(posedge clk);
    @(posedge clk);
    fe_v     <= 1'b1;
    fe_entry <= e;
    credits_used++;
    @(posedge clk);
    fe_v <= 1'b0;
  endtask

  task automatic write_reg(input logic fp, input reg_addr_t addr, input dpath_t data);
    wb_pkt_s w;
    w.w_v     = 1'b1;
    w.rd_addr = addr;
    w.rd_data = data;
    @(posedge clk);
    if (fp)
      fwb <= w;
    else
      iwb <= w;
    @(posedge clk);
    fwb.w_v <= 1'b0;
    iwb.w_v <= 1'b0;
    if (fp)
      fp_ref[addr] = data;
    else
      int_ref[addr] = data;
  endtask

  task automatic commit_load(input vaddr_t pc, input vaddr_t addr);
    commit_s c;
    c.v      = 1'b1;
    c.load_v = 1'b1;
    c.pc     = pc;
    c.vaddr  = addr;
    @(posedge clk);
    commit <= c;
    @(posedge clk);
    commit <= '0;
  endtask

  task automatic issue_test();
    fetch_entry_s e;
    write_reg(1'b0, 5'd3, {next_rand(), next_rand()});
    write_reg(1'b0, 5'd5, {next_rand(), next_rand()});
    write_reg(1'b0, 5'd0, {next_rand(), next_rand()});
    write_reg(1'b1, 5'd3, {next_rand(), next_rand()});
    write_reg(1'b1, 5'd5, {next_rand(), next_rand()});
    write_reg(1'b1, 5'd7, {next_rand(), next_rand()});
    e = make_entry(39'h100, 5'd3, 5'd5, 5'd7, 3'b000, {next_rand(), next_rand()});
    push_entry(e);
    check_dispatch(instr_pkt(e));
    // fp rs1 and fp rs3 through the immediate
    e = make_entry(39'h104, 5'd3, 5'd5, 5'd7, 3'b101, {next_rand(), next_rand()});
    push_entry(e);
    check_dispatch(instr_pkt(e));
    e = make_entry(39'h108, 5'd0, 5'd5, 5'd3, 3'b010, {next_rand(), next_rand()});
    push_entry(e);
    check_dispatch(instr_pkt(e));
    expect_quiet(4);
  endtask

  task automatic credit_hazard_test();
    fetch_entry_s e [4];
    int           pulses_before;
    check_value("credits at start", 64'(credits_avail()), 64'(queue_depth_lp));
    pulses_before = credit_pulses;
    @(posedge clk);
    hazard <= 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      e[i] = make_entry(39'h200 + 4 * i, 5'd5, 5'd3, 5'd7, 3'b000, {next_rand(), next_rand()});
      push_entry(e[i]);
    end
    check_value("credits after four entries", 64'(credits_avail()), 64'd0);
    expect_quiet(6);
    @(posedge clk);
    hazard <= 1'b0;
    for (int i = 0; i < 4; i++)
      check_dispatch(instr_pkt(e[i]));
    expect_quiet(4);
    check_value("fe_credit_o pulses", 64'(credit_pulses - pulses_before), 64'd4);
  endtask

  task automatic exception_test();
    fetch_entry_s  e;
    dispatch_pkt_s exp;
    e       = make_entry(39'h300, 5'd3, 5'd5, 5'd7, 3'b111, 64'hdead_beef);
    e.exc_v = 1'b1;
    e.exc   = 4'b1010;
    exp       = '0;
    exp.v     = 1'b1;
    exp.kind  = e_disp_fe_exc;
    exp.pc    = e.pc;
    exp.instr = e.instr;
    exp.exc   = e.exc;
    push_entry(e);
    check_dispatch(exp);
    expect_quiet(3);
  endtask

  task automatic priority_test();
    fetch_entry_s  e;
    dispatch_pkt_s wb_exp;
    dispatch_pkt_s ev_exp;
    late_wb_s      lw;
    lw.rd_addr     = 5'd9;
    lw.rd_data     = {next_rand(), next_rand()};
    lw.irf_w_v     = 1'b1;
    lw.frf_w_v     = 1'b0;
    wb_exp         = '0;
    wb_exp.v       = 1'b1;
    wb_exp.kind    = e_disp_late_wb;
    wb_exp.rd_addr = lw.rd_addr;
    wb_exp.rs2     = lw.rd_data;
    // unforced writeback waits behind a ready entry
    @(posedge clk);
    hazard <= 1'b1;
    e = make_entry(39'h400, 5'd3, 5'd5, 5'd7, 3'b000, 64'h11);
    push_entry(e);
    @(posedge clk);
    hazard    <= 1'b0;
    late_wb_v <= 1'b1;
    late_wb   <= lw;
    check_dispatch(instr_pkt(e));
    check_dispatch(wb_exp);
    @(posedge clk);
    late_wb_v <= 1'b0;
    hazard    <= 1'b1;
    // forced writeback jumps the ready entry
    e = make_entry(39'h404, 5'd5, 5'd3, 5'd7, 3'b000, 64'h22);
    push_entry(e);
    @(posedge clk);
    hazard        <= 1'b0;
    late_wb_v     <= 1'b1;
    late_wb_force <= 1'b1;
    check_dispatch(wb_exp);
    @(posedge clk);
    late_wb_v     <= 1'b0;
    late_wb_force <= 1'b0;
    check_dispatch(instr_pkt(e));
    // stalled head lets an unforced writeback through
    @(posedge clk);
    hazard <= 1'b1;
    e = make_entry(39'h408, 5'd3, 5'd3, 5'd7, 3'b000, 64'h33);
    push_entry(e);
    @(posedge clk);
    late_wb_v <= 1'b1;
    check_dispatch(wb_exp);
    @(posedge clk);
    late_wb_v <= 1'b0;
    hazard    <= 1'b0;
    check_dispatch(instr_pkt(e));
    ev_exp      = '0;
    ev_exp.v    = 1'b1;
    ev_exp.kind = e_disp_resume;
    @(posedge clk);
    resume      <= 1'b1;
    irq_pending <= 1'b1;
    check_dispatch(ev_exp);
    @(posedge clk);
    resume <= 1'b0;
    ev_exp.kind = e_disp_interrupt;
    check_dispatch(ev_exp);
    @(posedge clk);
    irq_pending <= 1'b0;
    expect_quiet(3);
  endtask

  task automatic prefetch_test();
    vaddr_t        pc;
    vaddr_t        base;
    vaddr_t        stride;
    fetch_entry_s  e;
    commit_s       c;
    dispatch_pkt_s exp;
    pc     = 39'h500;
    base   = 39'h40_0000_1000;
    stride = 39'h40;
    commit_load(pc, base);
    commit_load(pc, base + stride);
    // entry arrives with the third load and goes ahead of the prefetches
    e        = make_entry(39'h504, 5'd5, 5'd5, 5'd7, 3'b000, 64'h44);
    c.v      = 1'b1;
    c.load_v = 1'b1;
    c.pc     = pc;
    c.vaddr  = base + 2 * stride;
    @(posedge clk);
    commit   <= c;
    fe_v     <= 1'b1;
    fe_entry <= e;
    credits_used++;
    @(posedge clk);
    commit <= '0;
    fe_v   <= 1'b0;
    check_dispatch(instr_pkt(e));
    exp      = '0;
    exp.v    = 1'b1;
    exp.kind = e_disp_prefetch;
    for (int k = 3; k <= 5; k++)
    begin
      exp.rs1 = dpath_t'(base + k * stride);
      check_dispatch(exp);
    end
    expect_quiet(6);
  endtask

  task automatic clear_test();
    fetch_entry_s e;
    int           pulses_before;
    @(posedge clk);
    hazard <= 1'b1;
    for (int i = 0; i < 3; i++)
      push_entry(make_entry(39'h600 + 4 * i, 5'd3, 5'd5, 5'd7, 3'b000, 64'h55));
    pulses_before = credit_pulses;
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear  <= 1'b0;
    hazard <= 1'b0;
    expect_quiet(8);
    check_value("fe_credit_o pulses after clear", 64'(credit_pulses - pulses_before), 64'd0);
    // front end restarts with a full credit count
    credits_used = 0;
    pulse_base   = credit_pulses;
    e = make_entry(39'h610, 5'd5, 5'd3, 5'd7, 3'b000, 64'h66);
    push_entry(e);
    check_dispatch(instr_pkt(e));
    expect_quiet(3);
  endtask

  initial
  begin
    rst_n         <= 1'b0;
    fe_v          <= 1'b0;
    fe_entry      <= '0;
    clear         <= 1'b0;
    hazard        <= 1'b0;
    resume        <= 1'b0;
    irq_pending   <= 1'b0;
    iwb           <= '0;
    fwb           <= '0;
    late_wb_v     <= 1'b0;
    late_wb_force <= 1'b0;
    late_wb       <= '0;
    commit        <= '0;
    for (int r = 0; r < num_regs; r++)
    begin
      int_ref[r] = '0;
      fp_ref[r]  = '0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!dispatch.v && !late_wb_yumi && !fe_credit)
      else
      begin
        errors++;
        $display("outputs not idle right after reset");
      end
    issue_test();
    credit_hazard_test();
    exception_test();
    priority_test();
    prefetch_test();
    clear_test();
    $display("checks done: %0d errors, %0d monitor errors", errors, monitor_errors);
    if (errors + monitor_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: source/be_scheduler.sv
// back-end scheduler: issue queue, register files, dispatch arbiter and stride prefetcher
`timescale 1ns/10ps

module be_scheduler
  #(parameter int queue_depth_p      = 4
    , parameter int prefetch_depth_p = 3)
  (input  logic                          clk_i
   , input  logic                        rst_n_i
   , input  logic                        fe_v_i
   , input  sched_pkt_pkg::fetch_entry_s  fe_entry_i
   , input  logic                        clear_i
   , input  logic                        hazard_i
   , input  logic                        resume_i
   , input  logic                        irq_pending_i
   , input  sched_pkt_pkg::wb_pkt_s       iwb_i
   , input  sched_pkt_pkg::wb_pkt_s       fwb_i
   , input  logic                        late_wb_v_i
   , input  logic                        late_wb_force_i
   , input  sched_pkt_pkg::late_wb_s      late_wb_i
   , input  sched_pkt_pkg::commit_s       commit_i
   , output logic                        fe_credit_o
   , output logic                        late_wb_yumi_o
   , output sched_pkt_pkg::dispatch_pkt_s dispatch_o
  );

  import sched_cfg_pkg::*;
  import sched_pkt_pkg::*;

  fetch_entry_s head;
  logic         head_v;
  logic         deq;
  reg_addr_t    irf_addr [2];
  reg_addr_t    frf_addr [3];
  int_word_t    irf_rs [2];
  fp_word_t     frf_rs [3];
  logic         pref_v;
  logic         pref_yumi;
  vaddr_t       pref_addr;

  // rs1, rs2 and rs3 fields of the head instruction
  assign irf_addr[0] = head.instr[19:15];
  assign irf_addr[1] = head.instr[24:20];
  assign frf_addr[0] = head.instr[19:15];
  assign frf_addr[1] = head.instr[24:20];
  assign frf_addr[2] = head.instr[31:27];

  issue_queue #(.queue_depth_p(queue_depth_p)) i_queue
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .clear_i(clear_i)
     , .fe_v_i(fe_v_i), .fe_entry_i(fe_entry_i), .deq_i(deq)
     , .head_v_o(head_v), .head_o(head), .fe_credit_o(fe_credit_o));

  sched_regfile #(.data_t(int_word_t), .read_ports_p(2), .zero_reg_p(1'b1)) i_int_rf
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .wb_i(iwb_i)
     , .rs_addr_i(irf_addr), .rs_data_o(irf_rs));

  sched_regfile #(.data_t(fp_word_t), .read_ports_p(3), .zero_reg_p(1'b0)) i_fp_rf
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .wb_i(fwb_i)
     , .rs_addr_i(frf_addr), .rs_data_o(frf_rs));

  dispatch_arbiter i_arbiter
    (.head_v_i(head_v), .head_i(head), .hazard_i(hazard_i)
     , .resume_i(resume_i), .irq_pending_i(irq_pending_i)
     , .late_wb_v_i(late_wb_v_i), .late_wb_force_i(late_wb_force_i), .late_wb_i(late_wb_i)
     , .irf_rs_i(irf_rs), .frf_rs_i(frf_rs)
     , .pref_v_i(pref_v), .pref_addr_i(pref_addr)
     , .deq_o(deq), .late_wb_yumi_o(late_wb_yumi_o), .pref_yumi_o(pref_yumi)
     , .dispatch_o(dispatch_o));

  stride_prefetcher #(.prefetch_depth_p(prefetch_depth_p)) i_prefetcher
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .commit_i(commit_i)
     , .yumi_i(pref_yumi), .v_o(pref_v), .addr_o(pref_addr));

endmodule

// File: source/stride_prefetcher.sv
// stride prefetcher: detects a repeating load stride and queues prefetch addresses
`timescale 1ns/10ps

module stride_prefetcher
  #(parameter int prefetch_depth_p = 3)
  (input  logic                   clk_i
   , input  logic                 rst_n_i
   , input  sched_pkt_pkg::commit_s commit_i
   , input  logic                 yumi_i
   , output logic                 v_o
   , output sched_cfg_pkg::vaddr_t addr_o
  );

  import sched_cfg_pkg::*;

  localparam int rem_width_lp = $clog2(prefetch_depth_p + 1);

  vaddr_t                  track_pc_r;
  vaddr_t                  last_addr_r;
  vaddr_t                  stride_r;
  // 0 idle, 1 one address seen, 2 stride known
  logic [1:0]              match_cnt_r;
  vaddr_t                  next_addr_r;
  vaddr_t                  pref_stride_r;
  logic [rem_width_lp-1:0] remaining_r;
  logic                    load_commit;
  logic                    same_pc;
  vaddr_t                  delta;
  logic                    confirm;

  assign load_commit = commit_i.v & commit_i.load_v;
  assign same_pc     = (match_cnt_r != 2'd0) & (commit_i.pc == track_pc_r);
  assign delta       = commit_i.vaddr - last_addr_r;
  assign confirm     = load_commit & same_pc & (match_cnt_r == 2'd2)
                       & (delta == stride_r) & (delta != '0);

  // track a single load pc, any other pc starts over
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      track_pc_r  <= '0;
      last_addr_r <= '0;
      stride_r    <= '0;
      match_cnt_r <= 2'd0;
    end
    else if (load_commit)
    begin
      last_addr_r <= commit_i.vaddr;
      if (same_pc)
      begin
        stride_r    <= delta;
        match_cnt_r <= 2'd2;
      end
      else
      begin
        track_pc_r  <= commit_i.pc;
        match_cnt_r <= 2'd1;
      end
    end
  end

  // a fresh confirmation replaces whatever is still pending
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      remaining_r <= '0;
    end
    else if (confirm)
    begin
      remaining_r <= rem_width_lp'(prefetch_depth_p);
    end
    else if (yumi_i && v_o)
    begin
      remaining_r <= remaining_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (confirm)
    begin
      next_addr_r   <= commit_i.vaddr + delta;
      pref_stride_r <= delta;
    end
    else if (yumi_i && v_o)
    begin
      next_addr_r <= next_addr_r + pref_stride_r;
    end
  end

  assign v_o    = (remaining_r != '0);
  assign addr_o = next_addr_r;

endmodule

// File: source/dispatch_arbiter.sv
// dispatch arbiter: picks one source per cycle by fixed priority and builds its packet
`timescale 1ns/10ps

module dispatch_arbiter
  (input  logic                          head_v_i
   , input  sched_pkt_pkg::fetch_entry_s  head_i
   , input  logic                        hazard_i
   , input  logic                        resume_i
   , input  logic                        irq_pending_i
   , input  logic                        late_wb_v_i
   , input  logic                        late_wb_force_i
   , input  sched_pkt_pkg::late_wb_s      late_wb_i
   , input  sched_cfg_pkg::int_word_t     irf_rs_i [2]
   , input  sched_cfg_pkg::fp_word_t      frf_rs_i [3]
   , input  logic                        pref_v_i
   , input  sched_cfg_pkg::vaddr_t        pref_addr_i
   , output logic                        deq_o
   , output logic                        late_wb_yumi_o
   , output logic                        pref_yumi_o
   , output sched_pkt_pkg::dispatch_pkt_s dispatch_o
  );

  import sched_cfg_pkg::*;

  logic instr_ready;
  logic wb_sel;
  logic resume_sel;
  logic irq_sel;
  logic head_sel;
  logic pref_sel;

  assign instr_ready = head_v_i & ~hazard_i;

  // late writeback first, there is no back-pressure to hold it off
  assign wb_sel     = late_wb_v_i & (late_wb_force_i | ~instr_ready);
  assign resume_sel = ~wb_sel & ~hazard_i & resume_i;
  assign irq_sel    = ~wb_sel & ~hazard_i & ~resume_i & irq_pending_i;
  assign head_sel   = ~wb_sel & ~resume_sel & ~irq_sel & instr_ready;
  // prefetches only fill slots nobody else wants
  assign pref_sel   = ~wb_sel & ~resume_sel & ~irq_sel & ~head_sel & pref_v_i;

  assign deq_o          = head_sel;
  assign late_wb_yumi_o = wb_sel;
  assign pref_yumi_o    = pref_sel;

  always_comb
  begin
    dispatch_o      = '0;
    dispatch_o.kind = e_disp_idle;
    if (wb_sel)
    begin
      dispatch_o.kind    = e_disp_late_wb;
      dispatch_o.rd_addr = late_wb_i.rd_addr;
      dispatch_o.rs2     = late_wb_i.rd_data;
    end
    else if (resume_sel)
    begin
      dispatch_o.kind = e_disp_resume;
    end
    else if (irq_sel)
    begin
      dispatch_o.kind = e_disp_interrupt;
    end
    else if (head_sel)
    begin
      dispatch_o.pc    = head_i.pc;
      dispatch_o.instr = head_i.instr;
      if (head_i.exc_v)
      begin
        // operands stay zero for a fetch fault
        dispatch_o.kind = e_disp_fe_exc;
        dispatch_o.exc  = head_i.exc;
      end
      else
      begin
        dispatch_o.kind    = e_disp_instr;
        dispatch_o.rd_addr = head_i.instr[11:7];
        dispatch_o.rs1     = head_i.frs1_v ? dpath_t'(frf_rs_i[0]) : irf_rs_i[0];
        dispatch_o.rs2     = head_i.frs2_v ? dpath_t'(frf_rs_i[1]) : irf_rs_i[1];
        // fused fp ops take rs3 through the immediate slot
        dispatch_o.imm     = head_i.frs3_v ? dpath_t'(frf_rs_i[2]) : head_i.imm;
      end
    end
    else if (pref_sel)
    begin
      dispatch_o.kind = e_disp_prefetch;
      dispatch_o.rs1  = dpath_t'(pref_addr_i);
    end
    dispatch_o.v = wb_sel | resume_sel | irq_sel | head_sel | pref_sel;
  end

endmodule

// File: source/sched_regfile.sv
// scheduler register file: generic payload, combinational read ports, optional x0
`timescale 1ns/10ps

module sched_regfile
  #(parameter type data_t       = sched_cfg_pkg::int_word_t
    , parameter int read_ports_p = 2
    , parameter bit zero_reg_p   = 1'b1)
  (input  logic                      clk_i
   , input  logic                    rst_n_i
   , input  sched_pkt_pkg::wb_pkt_s   wb_i
   , input  sched_cfg_pkg::reg_addr_t rs_addr_i [read_ports_p]
   , output data_t                   rs_data_o [read_ports_p]
  );

  import sched_cfg_pkg::*;

  data_t regs_r [num_regs];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        regs_r[i] <= '0;
      end
    end
    else if (wb_i.w_v)
    begin
      regs_r[wb_i.rd_addr] <= data_t'(wb_i.rd_data);
    end
  end

  // x0 may still be written, it just never reads back
  always_comb
  begin
    for (int p = 0; p < read_ports_p; p++)
    begin
      if (zero_reg_p && (rs_addr_i[p] == '0))
      begin
        rs_data_o[p] = '0;
      end
      else
      begin
        rs_data_o[p] = regs_r[rs_addr_i[p]];
      end
    end
  end

endmodule

// File: source/issue_queue.sv
// issue queue: circular buffer of fetch entries that returns one credit per dequeue
`timescale 1ns/10ps

module issue_queue
  #(parameter int queue_depth_p = 4)
  (input  logic                         clk_i
   , input  logic                       rst_n_i
   , input  logic                       clear_i
   , input  logic                       fe_v_i
   , input  sched_pkt_pkg::fetch_entry_s fe_entry_i
   , input  logic                       deq_i
   , output logic                       head_v_o
   , output sched_pkt_pkg::fetch_entry_s head_o
   , output logic                       fe_credit_o
  );

  import sched_pkt_pkg::*;

  localparam int ptr_width_lp = (queue_depth_p > 1) ? $clog2(queue_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(queue_depth_p + 1);

  fetch_entry_s            mem_r [queue_depth_p];
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    credit_r;
  logic                    enq;
  logic                    deq;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    next_ptr = (ptr == ptr_width_lp'(queue_depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // front end only sends while it holds a credit, so no full check
  assign enq = fe_v_i & ~clear_i;
  assign deq = deq_i & head_v_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r   <= '0;
      rptr_r   <= '0;
      count_r  <= '0;
      credit_r <= 1'b0;
    end
    else if (clear_i)
    begin
      // flushed entries give no credit back
      wptr_r   <= '0;
      rptr_r   <= '0;
      count_r  <= '0;
      credit_r <= 1'b0;
    end
    else
    begin
      if (enq)
      begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (deq)
      begin
        rptr_r <= next_ptr(rptr_r);
      end
      count_r  <= count_r + cnt_width_lp'(enq) - cnt_width_lp'(deq);
      credit_r <= deq;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      mem_r[wptr_r] <= fe_entry_i;
    end
  end

  assign head_v_o    = (count_r != '0);
  assign head_o      = mem_r[rptr_r];
  assign fe_credit_o = credit_r;

endmodule

// File: source/sched_pkt_pkg.sv
// scheduler packets: fetch entries, register writes, commits and dispatch
package sched_pkt_pkg;

  import sched_cfg_pkg::*;

  // exception flags raised by the front end
  typedef struct packed {
    logic illegal_instr;
    logic instr_page_fault;
    logic instr_access_fault;
    logic icache_miss;
  } fe_exc_s;

  typedef struct packed {
    vaddr_t  pc;
    instr_t  instr;
    dpath_t  imm;
    logic    exc_v;
    fe_exc_s exc;
    // operand comes from the fp file when set
    logic    frs1_v;
    logic    frs2_v;
    logic    frs3_v;
  } fetch_entry_s;

  typedef struct packed {
    logic      w_v;
    reg_addr_t rd_addr;
    dpath_t    rd_data;
  } wb_pkt_s;

  typedef struct packed {
    reg_addr_t rd_addr;
    dpath_t    rd_data;
    logic      irf_w_v;
    logic      frf_w_v;
  } late_wb_s;

  typedef struct packed {
    logic   v;
    logic   load_v;
    vaddr_t pc;
    vaddr_t vaddr;
  } commit_s;

  typedef struct packed {
    logic       v;
    disp_kind_e kind;
    vaddr_t     pc;
    instr_t     instr;
    reg_addr_t  rd_addr;
    dpath_t     rs1;
    dpath_t     rs2;
    dpath_t     imm;
    fe_exc_s    exc;
  } dispatch_pkt_s;

endpackage

// File: source/sched_cfg_pkg.sv
// scheduler configuration: address and register widths, payload types, dispatch kinds
package sched_cfg_pkg;

  localparam int vaddr_width    = 39;
  localparam int reg_addr_width = 5;
  localparam int num_regs       = 32;

  typedef logic [31:0]               instr_t;
  typedef logic [vaddr_width-1:0]    vaddr_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [63:0]               int_word_t;
  typedef logic [63:0]               dpath_t;

  // IEEE double layout, kept apart from the integer word
  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] mant;
  } fp_word_t;

  typedef enum logic [2:0] {
    e_disp_idle      = 3'd0,
    e_disp_instr     = 3'd1,
    e_disp_fe_exc    = 3'd2,
    e_disp_late_wb   = 3'd3,
    e_disp_resume    = 3'd4,
    e_disp_interrupt = 3'd5,
    e_disp_prefetch  = 3'd6
  } disp_kind_e;

endpackage
